//--- alu_rs_cluster.f
rtl/alu_rs_pkg.sv
rtl/rs_if.sv
rtl/rs_dispatch.sv
rtl/rs_entry.sv
rtl/alu_issue.sv
rtl/alu_rs_cluster.sv
tb/alu_rs_tb.sv

//--- rtl/alu_issue.sv
/* issue stage: grants the lowest ready entry, runs the 32-bit ALU
   and registers the result onto the common result bus */
`default_nettype none

module alu_issue import alu_rs_pkg::*; #(
    parameter int NUM_ENTRIES = 4
) (
    input  wire          clk_in,
    input  wire          rst_in,
    input  wire          rdy_in,
    input  wire          flush,
    rs_issue_if.issue    entries [NUM_ENTRIES],
    output logic         result_valid,
    output tag_t         result_tag,
    output word_t        result_value
);

    logic [NUM_ENTRIES-1:0] ready_vec;
    logic [NUM_ENTRIES-1:0] grant_oh;
    logic                   any_grant;
    alu_op_e                op_arr [NUM_ENTRIES];
    tag_t                   tag_arr [NUM_ENTRIES];
    word_t                  v1_arr [NUM_ENTRIES];
    word_t                  v2_arr [NUM_ENTRIES];
    alu_op_e                sel_op;
    tag_t                   sel_tag;
    word_t                  sel_v1;
    word_t                  sel_v2;
    logic [4:0]             shamt;
    word_t                  alu_out;

    for (genvar i = 0; i < NUM_ENTRIES; i++)
    begin : g_req
        assign ready_vec[i]      = entries[i].ready;
        assign op_arr[i]         = entries[i].op;
        assign tag_arr[i]        = entries[i].tag;
        assign v1_arr[i]         = entries[i].v1;
        assign v2_arr[i]         = entries[i].v2;
        assign entries[i].grant  = grant_oh[i];
    end

    assign grant_oh  = ready_vec & (~ready_vec + 1'b1);    // isolate lowest set bit
    assign any_grant = |ready_vec;

    always_comb
    begin
        sel_op  = ADD;
        sel_tag = '0;
        sel_v1  = '0;
        sel_v2  = '0;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            if (grant_oh[i])
            begin
                sel_op  = op_arr[i];
                sel_tag = tag_arr[i];
                sel_v1  = v1_arr[i];
                sel_v2  = v2_arr[i];
            end
        end
    end

    assign shamt = sel_v2[4:0];

    always_comb
    begin
        case (sel_op)
            ADD:     alu_out = sel_v1 + sel_v2;
            SUB:     alu_out = sel_v1 - sel_v2;
            AND:     alu_out = sel_v1 & sel_v2;
            OR:      alu_out = sel_v1 | sel_v2;
            XOR:     alu_out = sel_v1 ^ sel_v2;
            SLL:     alu_out = sel_v1 << shamt;
            SRL:     alu_out = sel_v1 >> shamt;
            SRA:     alu_out = word_t'($signed(sel_v1) >>> shamt);
            SLT:     alu_out = ($signed(sel_v1) < $signed(sel_v2)) ? word_t'(1) : '0;
            SLTU:    alu_out = (sel_v1 < sel_v2) ? word_t'(1) : '0;
            default: alu_out = '0;
        endcase
    end

    // result bus, one pulse per granted entry
    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            result_valid <= 1'b0;
        end
        else if (rdy_in)
        begin
            result_valid <= any_grant && !flush;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && any_grant)
        begin
            result_tag   <= sel_tag;
            result_value <= alu_out;
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu_rs_cluster.sv
/* ALU reservation station top: dispatch, the entry array
   and the issue stage with its result broadcast */
`default_nettype none

module alu_rs_cluster import alu_rs_pkg::*; #(
    parameter int NUM_ENTRIES = 4   // 2 to 16
) (
    input  wire            clk_in,
    input  wire            rst_in,
    input  wire            rdy_in,      // low freezes all state
    input  wire            flush,
    input  wire            dispatch_valid,
    input  wire alu_op_e   dispatch_op,
    input  wire tag_t      dispatch_tag,
    input  wire            src1_ready,
    input  wire tag_t      src1_tag,
    input  wire word_t     src1_value,
    input  wire            src2_ready,
    input  wire tag_t      src2_tag,
    input  wire word_t     src2_value,
    output logic           full,
    output logic           result_valid,
    output tag_t           result_tag,
    output word_t          result_value
);

    operand_t src1;
    operand_t src2;

    rs_alloc_if alloc_if [NUM_ENTRIES] ();
    rs_issue_if issue_if [NUM_ENTRIES] ();

    assign src1 = '{ready: src1_ready, tag: src1_tag, value: src1_value};
    assign src2 = '{ready: src2_ready, tag: src2_tag, value: src2_value};

    rs_dispatch #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) rs_dispatch_inst (
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .src1           (src1),
        .src2           (src2),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value),
        .flush          (flush),
        .full           (full),
        .slots          (alloc_if)
    );

    for (genvar i = 0; i < NUM_ENTRIES; i++)
    begin : g_entry
        rs_entry rs_entry_inst (
            .clk_in       (clk_in),
            .rst_in       (rst_in),
            .rdy_in       (rdy_in),
            .flush        (flush),
            .result_valid (result_valid),   // every entry snoops the bus
            .result_tag   (result_tag),
            .result_value (result_value),
            .slot         (alloc_if[i]),
            .iss          (issue_if[i])
        );
    end

    alu_issue #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) alu_issue_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .flush        (flush),
        .entries      (issue_if),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_value (result_value)
    );

endmodule

`default_nettype wire

//--- rtl/alu_rs_pkg.sv
/* word and tag widths, their types, the ALU opcode enum,
   the operand struct and the result-bus snoop function */
`default_nettype none

package alu_rs_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 5;   // 32 rename slots

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,    // signed compare, 1 or 0
        SLTU = 4'd9     // unsigned compare
    } alu_op_e;

    // tag only means something while ready is low
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t value;
    } operand_t;

    // take the bus value if this operand is waiting on the broadcast tag
    function automatic operand_t snoop_operand(operand_t opnd, logic bus_valid,
                                               tag_t bus_tag, word_t bus_value);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus_valid && opnd.tag == bus_tag)
        begin
            res.ready = 1'b1;
            res.value = bus_value;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- rtl/rs_dispatch.sv
/* dispatch stage: picks the lowest free entry, raises full,
   and forwards a result on the bus into the incoming operands */
`default_nettype none

module rs_dispatch import alu_rs_pkg::*; #(
    parameter int NUM_ENTRIES = 4
) (
    input  wire                 dispatch_valid,
    input  wire alu_op_e        dispatch_op,
    input  wire tag_t           dispatch_tag,
    input  wire operand_t       src1,
    input  wire operand_t       src2,
    input  wire                 result_valid,
    input  wire tag_t           result_tag,
    input  wire word_t          result_value,
    input  wire                 flush,
    output logic                full,
    rs_alloc_if.dispatch        slots [NUM_ENTRIES]
);

    logic [NUM_ENTRIES-1:0] busy_vec;
    logic [NUM_ENTRIES-1:0] free_vec;
    logic [NUM_ENTRIES-1:0] free_oh;
    logic [NUM_ENTRIES-1:0] alloc_oh;
    logic                   accept;
    operand_t               src1_fwd;
    operand_t               src2_fwd;

    assign free_vec = ~busy_vec;
    assign free_oh  = free_vec & (~free_vec + 1'b1);    // lowest free entry

    assign full = &busy_vec;

    // a dispatch in a flush cycle is dropped
    assign accept   = dispatch_valid && !full && !flush;
    assign alloc_oh = accept ? free_oh : '0;

    // a producer finishing right now would otherwise be missed by the new entry
    always_comb
    begin
        src1_fwd = snoop_operand(src1, result_valid, result_tag, result_value);
        src2_fwd = snoop_operand(src2, result_valid, result_tag, result_value);
    end

    for (genvar i = 0; i < NUM_ENTRIES; i++)
    begin : g_slot
        assign busy_vec[i]    = slots[i].busy;
        assign slots[i].alloc = alloc_oh[i];
        assign slots[i].op    = dispatch_op;
        assign slots[i].tag   = dispatch_tag;
        assign slots[i].src1  = src1_fwd;
        assign slots[i].src2  = src2_fwd;
    end

endmodule

`default_nettype wire

//--- rtl/rs_entry.sv
/* one reservation station entry: holds an instruction and its
   operands, wakes them from the result bus, requests issue */
`default_nettype none

module rs_entry import alu_rs_pkg::*; (
    input  wire          clk_in,
    input  wire          rst_in,
    input  wire          rdy_in,
    input  wire          flush,
    input  wire          result_valid,
    input  wire tag_t    result_tag,
    input  wire word_t   result_value,
    rs_alloc_if.entry    slot,
    rs_issue_if.entry    iss
);

    logic     busy_q;
    alu_op_e  op_q;
    tag_t     tag_q;
    operand_t src1_q;
    operand_t src2_q;

    // occupancy
    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy_q <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (flush)
            begin
                busy_q <= 1'b0;
            end
            else if (slot.alloc)
            begin
                busy_q <= 1'b1;
            end
            else if (iss.grant)
            begin
                busy_q <= 1'b0;     // leaves for the ALU this edge
            end
        end
    end

    // instruction payload
    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (slot.alloc)
            begin
                op_q   <= slot.op;
                tag_q  <= slot.tag;
                src1_q <= slot.src1;    // already forwarded by dispatch
                src2_q <= slot.src2;
            end
            else if (busy_q)
            begin
                src1_q <= snoop_operand(src1_q, result_valid, result_tag, result_value);
                src2_q <= snoop_operand(src2_q, result_valid, result_tag, result_value);
            end
        end
    end

    assign slot.busy = busy_q;

    assign iss.ready = busy_q && src1_q.ready && src2_q.ready;
    assign iss.op    = op_q;
    assign iss.tag   = tag_q;
    assign iss.v1    = src1_q.value;
    assign iss.v2    = src2_q.value;

endmodule

`default_nettype wire

//--- rtl/rs_if.sv
/* rs_alloc_if carries a dispatched instruction into an entry,
   rs_issue_if carries a waiting instruction out to the issue stage */
`default_nettype none

interface rs_alloc_if import alu_rs_pkg::*; ();

    logic     alloc;    // write the entry this cycle
    alu_op_e  op;
    tag_t     tag;
    operand_t src1;
    operand_t src2;
    logic     busy;     // entry occupied

    modport dispatch (
        output alloc,
        output op,
        output tag,
        output src1,
        output src2,
        input  busy
    );

    modport entry (
        input  alloc,
        input  op,
        input  tag,
        input  src1,
        input  src2,
        output busy
    );

endinterface

interface rs_issue_if import alu_rs_pkg::*; ();

    logic    ready;     // busy with both operands known
    alu_op_e op;
    tag_t    tag;
    word_t   v1;
    word_t   v2;
    logic    grant;

    modport entry (
        output ready,
        output op,
        output tag,
        output v1,
        output v2,
        input  grant
    );

    modport issue (
        input  ready,
        input  op,
        input  tag,
        input  v1,
        input  v2,
        output grant
    );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module alu_rs_tb -Mdir "$BUILD_DIR" -f alu_rs_cluster.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Valu_rs_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG" ]; then
    echo "simulation log is empty"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

exit 0

//--- tb/alu_rs_tb.sv
/* testbench for the ALU reservation station: stimulus, reference
   model, checks on the result bus, watchdog and report */
`default_nettype none

module alu_rs_tb import alu_rs_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 8;
    localparam int N_TAGS          = 32;
    localparam int N_IND           = 20;    // independent ops per traffic run
    localparam int NEVER_A         = 30;    // source tags nobody produces
    localparam int NEVER_B         = 31;
    localparam int WATCHDOG_CYCLES = 2 * N_IND * 10 + 300;

    logic    clk_in = 1'b0;
    logic    rst_in;
    logic    rdy_in;
    logic    flush;
    logic    dispatch_valid;
    alu_op_e dispatch_op;
    tag_t    dispatch_tag;
    logic    src1_ready;
    tag_t    src1_tag;
    word_t   src1_value;
    logic    src2_ready;
    tag_t    src2_tag;
    word_t   src2_value;
    logic    full;
    logic    result_valid;
    tag_t    result_tag;
    word_t   result_value;

    // model, indexed by tag
    int      tag_state [N_TAGS];    // 0 free, 1 in flight, 2 must never appear
    alu_op_e m_op [N_TAGS];
    logic    m_rdy1 [N_TAGS];
    logic    m_rdy2 [N_TAGS];
    tag_t    m_src1 [N_TAGS];
    tag_t    m_src2 [N_TAGS];
    word_t   m_v1 [N_TAGS];
    word_t   m_v2 [N_TAGS];
    word_t   m_res [N_TAGS];
    int      acc_edge [N_TAGS];
    logic    lat_chk [N_TAGS];
    int      pending;
    int      edge_cnt;              // rdy_in-high edges only
    int      value_errs;
    int      other_errs;
    int      next_tag;
    int      n_entries;
    logic    pause_on;

    alu_rs_cluster alu_rs_cluster_inst (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            ADD:     r = a + b;
            SUB:     r = a + ~b + 32'd1;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLL:     r = a << sh;
            SRL:     r = a >> sh;
            SRA:     r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            SLT:     r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};   // sign decides
            SLTU:    r = {31'd0, a < b};
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic tag_t alloc_tag();
        tag_t t;
        for (int k = 0; k < N_TAGS; k++)
        begin
            t = tag_t'((next_tag + k) % N_TAGS);
            if (tag_state[t] == 0)
            begin
                next_tag = (next_tag + k + 1) % N_TAGS;
                return t;
            end
        end
        return '0;
    endfunction

    task automatic report_failure(input string msg);
        other_errs++;
        $display("%s (at %0t)", msg, $time);
    endtask

    // a producer that is still outstanding is named by its tag
    task automatic set_src(input int dep, input word_t v, output logic rdy,
                           output tag_t tg, output word_t val);
        rdy = 1'b1;
        tg  = '0;
        val = v;
        if (dep >= 0 && tag_state[dep] != 0)
        begin
            rdy = 1'b0;
            tg  = tag_t'(dep);
        end
        else if (dep >= 0)
        begin
            val = m_res[dep];
        end
    endtask

    task automatic send_op(input alu_op_e op, input int dep1, input int dep2, input word_t a,
                           input word_t b, input logic chk, output tag_t t);
        t = alloc_tag();
        m_op[t] = op;
        set_src(dep1, a, m_rdy1[t], m_src1[t], m_v1[t]);
        set_src(dep2, b, m_rdy2[t], m_src2[t], m_v2[t]);
        lat_chk[t]   = chk;
        tag_state[t] = 1;
        pending++;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_tag   = t;
        src1_ready     = m_rdy1[t];
        src1_tag       = m_src1[t];
        src1_value     = m_v1[t];
        src2_ready     = m_rdy2[t];
        src2_tag       = m_src2[t];
        src2_value     = m_v2[t];
        do
            @(posedge clk_in);
        while (!(rdy_in && !full));     // hold until accepted
        #1;
        dispatch_valid = 1'b0;
    endtask

    // one flush edge, after which nothing in flight may ever finish
    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk_in);
        #1;
        flush = 1'b0;
        for (int i = 0; i < N_TAGS; i++)
        begin
            if (tag_state[i] == 1)
            begin
                tag_state[i] = 2;
                pending--;
            end
        end
    endtask

    task automatic drain();
        while (pending != 0)
            @(posedge clk_in);
        @(posedge clk_in);
        #1;
    endtask

    task automatic wake_waiters(input tag_t p);
        for (int t = 0; t < N_TAGS; t++)
        begin
            if (tag_state[t] == 1 && !m_rdy1[t] && m_src1[t] == p)
            begin
                m_rdy1[t] = 1'b1;
                m_v1[t]   = m_res[p];   // model value, never the bus value
            end
            if (tag_state[t] == 1 && !m_rdy2[t] && m_src2[t] == p)
            begin
                m_rdy2[t] = 1'b1;
                m_v2[t]   = m_res[p];
            end
        end
    endtask

    task automatic check_result(input tag_t t, input word_t v);
        word_t exp;
        assert (tag_state[t] == 1)
        else report_failure($sformatf("result for tag %0d, which is not in flight", t));
        if (tag_state[t] == 1)
        begin
            assert (m_rdy1[t] && m_rdy2[t])
            else report_failure($sformatf("tag %0d finished before its producers", t));
            exp = ref_alu(m_op[t], m_v1[t], m_v2[t]);
            assert (v === exp)
            else
            begin
                value_errs++;
                $display("** Error at %0t: tag %0d gave %h, expected %h", $time, t, v, exp);
            end
            assert (!lat_chk[t] || edge_cnt - acc_edge[t] == 2)
            else report_failure($sformatf("tag %0d took %0d cycles instead of 2", t,
                                          edge_cnt - acc_edge[t]));
            m_res[t]     = exp;
            tag_state[t] = 0;
            pending--;
            wake_waiters(t);
        end
    endtask

    task automatic monitor_bus();
        logic  any_disp;
        logic  paused;
        logic  flushed;
        logic  full_q;
        logic  valid_q;
        tag_t  tag_q;
        word_t value_q;
        any_disp = 1'b0;
        paused   = 1'b0;
        flushed  = 1'b0;
        forever
        begin
            @(posedge clk_in);
            if (!rst_in)
            begin
                assert (any_disp || (!full && !result_valid))
                else report_failure("full or result_valid high before any dispatch");
                assert (!paused || (full === full_q && result_valid === valid_q &&
                                    result_tag === tag_q && result_value === value_q))
                else report_failure("outputs changed while rdy_in was low");
                assert (!flushed || (!full && !result_valid))
                else report_failure("full or result_valid still high after flush");
                if (rdy_in)
                begin
                    edge_cnt++;
                    if (dispatch_valid && !full && !flush)
                    begin
                        any_disp = 1'b1;
                        acc_edge[dispatch_tag] = edge_cnt;
                    end
                    if (result_valid)
                        check_result(result_tag, result_value);
                end
                full_q  = full;
                valid_q = result_valid;
                tag_q   = result_tag;
                value_q = result_value;
                paused  = !rdy_in;
                flushed = flush && rdy_in;
            end
        end
    endtask

    initial
    begin
        tag_t t;
        tag_t p;
        tag_t d1;
        tag_t d2;
        void'($urandom(23));
        n_entries  = alu_rs_cluster_inst.NUM_ENTRIES;
        pending    = 0;
        edge_cnt   = 0;
        value_errs = 0;
        other_errs = 0;
        next_tag   = 0;
        pause_on   = 1'b0;
        for (int i = 0; i < N_TAGS; i++)
            tag_state[i] = 0;
        tag_state[NEVER_A] = 2;
        tag_state[NEVER_B] = 2;
        rst_in         = 1'b1;
        rdy_in         = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = ADD;
        dispatch_tag   = '0;
        src1_ready     = 1'b0;
        src1_tag       = '0;
        src1_value     = '0;
        src2_ready     = 1'b0;
        src2_tag       = '0;
        src2_value     = '0;
        fork
            monitor_bus();
        join_none
        repeat (3) @(posedge clk_in);
        #1 rst_in = 1'b0;
        repeat (4) @(posedge clk_in);   // quiet bus after reset
        #1;

        for (int i = 0; i < N_IND; i++)
        begin
            send_op(alu_op_e'(4'(i % 10)), -1, -1, $urandom, $urandom, 1'b1, t);
            drain();
        end

        // chains: woken inside the entry, then forwarded at dispatch
        repeat (3)
        begin
            send_op(ADD, -1, -1, $urandom, $urandom, 1'b0, p);
            send_op(SUB, int'(p), -1, '0, $urandom, 1'b0, d1);
            send_op(XOR, int'(d1), int'(p), '0, '0, 1'b0, d2);
            send_op(SLT, int'(d2), int'(d1), '0, '0, 1'b0, t);
            drain();
            send_op(OR, -1, -1, $urandom, $urandom, 1'b0, p);
            @(posedge clk_in);
            #1;
            send_op(SRA, int'(p), -1, '0, $urandom, 1'b0, d1);    // p is on the bus now
            send_op(SLTU, int'(d1), int'(p), '0, '0, 1'b0, t);
            drain();
        end

        for (int i = 0; i < n_entries; i++)
            send_op(alu_op_e'(4'(i % 10)), NEVER_A, (i % 2 == 1) ? NEVER_B : -1,
                    '0, $urandom, 1'b0, t);
        @(posedge clk_in);
        assert (full)
        else report_failure("full stayed low with every entry waiting");
        #1;
        t = alloc_tag();
        tag_state[t]   = 2;             // dispatched while full, so it must be dropped
        dispatch_valid = 1'b1;
        dispatch_tag   = t;
        src1_ready     = 1'b1;
        src2_ready     = 1'b1;
        repeat (3) @(posedge clk_in);
        #1 dispatch_valid = 1'b0;
        repeat (4) @(posedge clk_in);
        #1;
        pulse_flush();
        repeat (4) @(posedge clk_in);
        #1;

        // flush lands on the edge where a ready entry issues
        send_op(ADD, -1, -1, $urandom, $urandom, 1'b0, t);
        pulse_flush();
        repeat (4) @(posedge clk_in);
        #1;

        pause_on = 1'b1;
        fork
            begin
                for (int i = 0; i < N_IND; i++)
                begin
                    send_op(alu_op_e'(4'(i % 10)), -1, -1, $urandom, $urandom, 1'b1, t);
                    drain();
                end
                pause_on = 1'b0;
            end
            begin
                while (pause_on)
                begin
                    @(posedge clk_in);
                    #1 rdy_in = ($urandom_range(3) != 0);
                end
                rdy_in = 1'b1;
            end
        join
        drain();
        repeat (10) @(posedge clk_in);

        $display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // all traffic phases together, with margin
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with %0d results still missing",
                 WATCHDOG_CYCLES, pending);
        $display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
